/* verilog/mul_pkg.sv */
`default_nettype none

package mul_pkg;

   // datapath widths
   parameter int XLEN   = 32;
   parameter int OPND_W = XLEN + 1;
   parameter int PROD_W = 2 * XLEN;

   // operations handled by the multiply / bit-manip pipe
   typedef enum logic [3:0] {
      OP_MUL    = 4'd0,
      OP_MULH   = 4'd1,
      OP_MULHSU = 4'd2,
      OP_MULHU  = 4'd3,
      OP_CLMUL  = 4'd4,
      OP_CLMULH = 4'd5,
      OP_CLMULR = 4'd6,
      OP_GREV   = 4'd7,
      OP_GORC   = 4'd8
   } mul_op_e;

   // request as presented at the pipe input, 68 bits
   typedef struct packed {
      mul_op_e         op;
      logic [XLEN-1:0] a;
      logic [XLEN-1:0] b;
   } mul_req_t;

   // E2 operands, 33 bits each with the sign folded into the top bit
   typedef struct packed {
      mul_op_e                  op;
      logic signed [OPND_W-1:0] a_ext;
      logic signed [OPND_W-1:0] b_ext;
   } mul_opnd_t;

   // E3 result register contents, 98 bits
   typedef struct packed {
      logic [PROD_W-1:0] product;
      logic [XLEN-1:0]   bitmanip;
      logic              bitmanip_sel;
      logic              low;
   } mul_res_t;

endpackage

`default_nettype wire

/* verilog/mul_issue_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_issue_stage
   import mul_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     reset_i,
   input  wire logic     valid_i,
   input  wire mul_req_t req_i,
   output logic         e1_valid_o,
   output mul_req_t     e1_req_o
);

   // valid travels down the pipe and is the only reset state here
   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         e1_valid_o <= 1'b0;
      end
      else
      begin
         e1_valid_o <= valid_i;
      end
   end

   // request payload, loaded only on a valid strobe
   always_ff @(posedge clk)
   begin
      if (valid_i)
      begin
         e1_req_o <= req_i;
      end
   end

endmodule

`default_nettype wire

/* verilog/mul_operand_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_operand_stage
   import mul_pkg::*;
(
   input  wire logic     clk,
   input  wire logic     reset_i,
   input  wire logic     e1_valid_i,
   input  wire mul_req_t e1_req_i,
   output logic         e2_valid_o,
   output mul_opnd_t    e2_opnd_o
);

   logic      rs1_sign;
   logic      rs2_sign;
   logic      rs1_neg;
   logic      rs2_neg;
   mul_opnd_t opnd_d;

   // MULH is signed x signed, MULHSU signed x unsigned, the rest unsigned
   assign rs1_sign = (e1_req_i.op == OP_MULH) || (e1_req_i.op == OP_MULHSU);
   assign rs2_sign = (e1_req_i.op == OP_MULH);

   assign rs1_neg = rs1_sign & e1_req_i.a[XLEN-1];
   assign rs2_neg = rs2_sign & e1_req_i.b[XLEN-1];

   // 33-bit operands so one signed multiplier covers all four flavours
   assign opnd_d.op    = e1_req_i.op;
   assign opnd_d.a_ext = {rs1_neg, e1_req_i.a};
   assign opnd_d.b_ext = {rs2_neg, e1_req_i.b};

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         e2_valid_o <= 1'b0;
      end
      else
      begin
         e2_valid_o <= e1_valid_i;
      end
   end

   always_ff @(posedge clk)
   begin
      if (e1_valid_i)
      begin
         e2_opnd_o <= opnd_d;
      end
   end

endmodule

`default_nettype wire

/* verilog/bitmanip_unit.sv */
`timescale 1ns/1ns
`default_nettype none

module bitmanip_unit
   import mul_pkg::*;
#(
   parameter int BITMANIP_EN = 1
)
(
   input  wire mul_op_e         op_i,
   input  wire logic [XLEN-1:0] a_i,
   input  wire logic [XLEN-1:0] b_i,
   output logic                 sel_o,
   output logic [XLEN-1:0]      result_o
);

   logic [2*XLEN-2:0] clmul_raw;
   logic [XLEN-1:0]   grev_val;
   logic [XLEN-1:0]   gorc_val;

   // one butterfly level: swap neighbouring groups of 2**stage bits
   function automatic logic [XLEN-1:0] swap_groups(input logic [XLEN-1:0] x, input int stage);
      logic [XLEN-1:0] mask;
      int              shamt;
      case (stage)
         0:       mask = 32'h5555_5555;
         1:       mask = 32'h3333_3333;
         2:       mask = 32'h0f0f_0f0f;
         3:       mask = 32'h00ff_00ff;
         default: mask = 32'h0000_ffff;
      endcase
      shamt = 1 << stage;
      return ((x & mask) << shamt) | ((x & ~mask) >> shamt);
   endfunction

   // carry-less product, 63 bits wide
   always_comb
   begin
      clmul_raw = '0;
      for (int i = 0; i < XLEN; i++)
      begin
         if (b_i[i])
         begin
            clmul_raw = clmul_raw ^ ({{(XLEN-1){1'b0}}, a_i} << i);
         end
      end
   end

   // grev swaps, gorc ors the swapped copy back in
   always_comb
   begin
      grev_val = a_i;
      gorc_val = a_i;
      for (int k = 0; k < 5; k++)
      begin
         if (b_i[k])
         begin
            grev_val = swap_groups(grev_val, k);
            gorc_val = gorc_val | swap_groups(gorc_val, k);
         end
      end
   end

   // multiplies and a disabled unit both leave sel low and the result zero
   always_comb
   begin
      sel_o    = 1'b0;
      result_o = '0;
      if (BITMANIP_EN == 1)
      begin
         case (op_i)
            OP_CLMUL:
            begin
               sel_o    = 1'b1;
               result_o = clmul_raw[XLEN-1:0];
            end
            OP_CLMULH:
            begin
               sel_o    = 1'b1;
               result_o = {1'b0, clmul_raw[2*XLEN-2:XLEN]};
            end
            OP_CLMULR:
            begin
               sel_o    = 1'b1;
               result_o = clmul_raw[2*XLEN-2:XLEN-1];
            end
            OP_GREV:
            begin
               sel_o    = 1'b1;
               result_o = grev_val;
            end
            OP_GORC:
            begin
               sel_o    = 1'b1;
               result_o = gorc_val;
            end
            default:
            begin
               sel_o    = 1'b0;
               result_o = '0;
            end
         endcase
      end
   end

endmodule

`default_nettype wire

/* verilog/mul_execute_stage.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_execute_stage
   import mul_pkg::*;
#(
   parameter int BITMANIP_EN = 1
)
(
   input  wire logic      clk,
   input  wire logic      reset_i,
   input  wire logic      e2_valid_i,
   input  wire mul_opnd_t e2_opnd_i,
   output logic [XLEN-1:0] result_o
);

   logic signed [OPND_W-1:0]   a_s;
   logic signed [OPND_W-1:0]   b_s;
   logic signed [2*OPND_W-1:0] prod_full;
   logic                       is_mul;
   logic                       bm_sel;
   logic [XLEN-1:0]            bm_result;
   mul_res_t                   res_d;
   mul_res_t                   res_e3;

   assign a_s = e2_opnd_i.a_ext;
   assign b_s = e2_opnd_i.b_ext;

   // 33 x 33 signed, only the low 64 bits matter
   assign prod_full = a_s * b_s;

   assign is_mul = (e2_opnd_i.op == OP_MUL) || (e2_opnd_i.op == OP_MULH) ||
                   (e2_opnd_i.op == OP_MULHSU) || (e2_opnd_i.op == OP_MULHU);

   bitmanip_unit #(
      .BITMANIP_EN (BITMANIP_EN)
   ) u_bitmanip (
      .op_i     (e2_opnd_i.op),
      .a_i      (e2_opnd_i.a_ext[XLEN-1:0]),
      .b_i      (e2_opnd_i.b_ext[XLEN-1:0]),
      .sel_o    (bm_sel),
      .result_o (bm_result)
   );

   // product forced to zero for non-multiplies so a disabled bit-manip op reads zero
   assign res_d.product      = is_mul ? prod_full[PROD_W-1:0] : '0;
   assign res_d.bitmanip     = bm_result;
   assign res_d.bitmanip_sel = bm_sel;
   assign res_d.low          = (e2_opnd_i.op == OP_MUL);

   always_ff @(posedge clk)
   begin
      if (reset_i)
      begin
         res_e3 <= '0;
      end
      else if (e2_valid_i)
      begin
         res_e3 <= res_d;
      end
   end

   // E3 output select
   always_comb
   begin
      if (res_e3.bitmanip_sel)
      begin
         result_o = res_e3.bitmanip;
      end
      else if (res_e3.low)
      begin
         result_o = res_e3.product[XLEN-1:0];
      end
      else
      begin
         result_o = res_e3.product[PROD_W-1:XLEN];
      end
   end

endmodule

`default_nettype wire

/* verilog/mul_top.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_top
   import mul_pkg::*;
#(
   parameter int BITMANIP_EN = 1
)
(
   input  wire logic      clk,
   input  wire logic      reset_i,
   input  wire logic      valid_i,
   input  wire mul_req_t  req_i,
   output logic [XLEN-1:0] result_o
);

   logic      e1_valid;
   mul_req_t  e1_req;
   logic      e2_valid;
   mul_opnd_t e2_opnd;

   mul_issue_stage u_issue (
      .clk        (clk),
      .reset_i    (reset_i),
      .valid_i    (valid_i),
      .req_i      (req_i),
      .e1_valid_o (e1_valid),
      .e1_req_o   (e1_req)
   );

   mul_operand_stage u_operand (
      .clk        (clk),
      .reset_i    (reset_i),
      .e1_valid_i (e1_valid),
      .e1_req_i   (e1_req),
      .e2_valid_o (e2_valid),
      .e2_opnd_o  (e2_opnd)
   );

   mul_execute_stage #(
      .BITMANIP_EN (BITMANIP_EN)
   ) u_execute (
      .clk        (clk),
      .reset_i    (reset_i),
      .e2_valid_i (e2_valid),
      .e2_opnd_i  (e2_opnd),
      .result_o   (result_o)
   );

endmodule

`default_nettype wire

/* include/mul_tb_model.svh */
`ifndef MUL_TB_MODEL_SVH
`define MUL_TB_MODEL_SVH

// shift-and-xor carry-less product
function automatic logic [62:0] model_clmul(input logic [31:0] a, input logic [31:0] b);
   logic [62:0] acc;
   acc = '0;
   for (int i = 0; i < 32; i++)
   begin
      if (b[i])
      begin
         acc = acc ^ (63'(a) << i);
      end
   end
   return acc;
endfunction

// generalized reverse / or-combine, bit by bit over the control
function automatic logic [31:0] model_grev_gorc(input logic [31:0] x,
                                                input logic [4:0]  ctrl,
                                                input bit          do_or);
   logic [31:0] r;
   logic [31:0] t;
   r = x;
   for (int k = 0; k < 5; k++)
   begin
      if (ctrl[k])
      begin
         for (int i = 0; i < 32; i++)
         begin
            t[i] = r[i ^ (1 << k)];
         end
         r = do_or ? (r | t) : t;
      end
   end
   return r;
endfunction

// expected result_o for one request
function automatic logic [31:0] model_result(input mul_op_e op,
                                             input logic [31:0] a,
                                             input logic [31:0] b);
   longint      s_s;
   longint      s_u;
   logic [63:0] u_u;
   logic [62:0] cl;
   s_s = longint'(signed'(a)) * longint'(signed'(b));
   s_u = longint'(signed'(a)) * longint'({32'b0, b});
   u_u = {32'b0, a} * {32'b0, b};
   cl  = model_clmul(a, b);
   case (op)
      OP_MUL:    return s_s[31:0];
      OP_MULH:   return s_s[63:32];
      OP_MULHSU: return s_u[63:32];
      OP_MULHU:  return u_u[63:32];
      OP_CLMUL:  return cl[31:0];
      OP_CLMULH: return {1'b0, cl[62:32]};
      OP_CLMULR: return cl[62:31];
      OP_GREV:   return model_grev_gorc(a, b[4:0], 1'b0);
      OP_GORC:   return model_grev_gorc(a, b[4:0], 1'b1);
      default:   return 32'h0;
   endcase
endfunction

`endif

/* verif/mul_tb.sv */
`timescale 1ns/1ns
`default_nettype none

module mul_tb
   import mul_pkg::*;
();

   localparam int          CLK_PERIOD   = 4;
   localparam int          RESET_CYCLES = 16;
   localparam int          NUM_RANDOM   = 20;
   localparam int          STREAM_LEN   = 48;
   localparam logic [31:0] SEED         = 32'h67ef_ff74;
   // isolated operations, each one costs four cycles
   localparam int          NUM_SINGLE   = 100 + 7 * NUM_RANDOM + 66 + 1;
   localparam int          RUN_CYCLES   = RESET_CYCLES + 4 * NUM_SINGLE + STREAM_LEN + 15;
   localparam int          TIMEOUT_NS   = (RUN_CYCLES + 200) * CLK_PERIOD;

   logic            clk;
   logic            reset_i;
   logic            valid_i;
   mul_req_t        req_i;
   logic [XLEN-1:0] result_o;
   int unsigned     seed_val;
   int              check_count;
   int              error_count;
   int              test_errors;
   logic [31:0]     corners [5];

   `include "mul_tb_model.svh"

   mul_top #(
      .BITMANIP_EN (1)
   ) DUT (
      .clk      (clk),
      .reset_i  (reset_i),
      .valid_i  (valid_i),
      .req_i    (req_i),
      .result_o (result_o)
   );

   initial
   begin
      clk = 1'b0;
      forever
      begin
         #(CLK_PERIOD / 2) clk = ~clk;
      end
   end

   initial
   begin
      #(TIMEOUT_NS);
      $display("timeout: the tests did not finish within %0d ns", TIMEOUT_NS);
      $display("*** TEST FAILED ***");
      $finish;
   end

   task automatic check_value(input logic [31:0] expected, input string what);
      check_count++;
      if (result_o !== expected)
      begin
         error_count++;
         test_errors++;
         $display("[ERROR] %0t ns result_o (%s) expected %h actual %h",
                  $time, what, expected, result_o);
      end
   endtask

   task automatic finish_test(input string name);
      $display("test %-10s done, %0d errors", name, test_errors);
      test_errors = 0;
   endtask

   // one isolated operation, result checked once it sits in E3
   task automatic run_op(input mul_op_e op, input logic [31:0] a, input logic [31:0] b);
      logic [31:0] expected;
      expected = model_result(op, a, b);
      @(negedge clk);
      valid_i  = 1'b1;
      req_i.op = op;
      req_i.a  = a;
      req_i.b  = b;
      @(negedge clk);
      valid_i = 1'b0;
      repeat (2) @(negedge clk);
      check_value(expected, op.name());
   endtask

   task automatic test_reset();
      @(negedge clk);
      check_value(32'h0, "after reset");
      finish_test("reset");
   endtask

   task automatic test_int_mul();
      mul_op_e ops [4] = '{OP_MUL, OP_MULH, OP_MULHSU, OP_MULHU};
      foreach (ops[k])
      begin
         foreach (corners[i])
         begin
            foreach (corners[j])
            begin
               run_op(ops[k], corners[i], corners[j]);
            end
         end
      end
      for (int r = 0; r < NUM_RANDOM; r++)
      begin
         foreach (ops[k])
         begin
            run_op(ops[k], $urandom(), $urandom());
         end
      end
      finish_test("int_mul");
   endtask

   task automatic test_clmul();
      mul_op_e ops [3] = '{OP_CLMUL, OP_CLMULH, OP_CLMULR};
      for (int r = 0; r < NUM_RANDOM; r++)
      begin
         foreach (ops[k])
         begin
            run_op(ops[k], $urandom(), $urandom());
         end
      end
      finish_test("clmul");
   endtask

   task automatic test_grev_gorc();
      logic [31:0] data;
      logic [31:0] reversed;
      data = $urandom();
      for (int c = 0; c < 32; c++)
      begin
         run_op(OP_GREV, data, c);
         run_op(OP_GORC, data, c);
      end
      // control 31 is a full bit reverse
      reversed = {<<{data}};
      run_op(OP_GREV, data, 32'd31);
      check_value(reversed, "grev 31 bit reverse");
      // a single set bit spreads over its whole byte
      run_op(OP_GORC, 32'h0000_1000, 32'd7);
      check_value(32'h0000_ff00, "gorc 7 byte fill");
      finish_test("grev_gorc");
   endtask

   // new op every cycle, the op from three edges back is checked
   task automatic test_stream();
      mul_op_e     op_q  [STREAM_LEN];
      logic [31:0] exp_q [STREAM_LEN];
      for (int i = 0; i < STREAM_LEN + 3; i++)
      begin
         @(negedge clk);
         if (i >= 3)
         begin
            check_value(exp_q[i-3], op_q[i-3].name());
         end
         if (i < STREAM_LEN)
         begin
            op_q[i]  = mul_op_e'($urandom_range(8, 0));
            valid_i  = 1'b1;
            req_i.op = op_q[i];
            req_i.a  = $urandom();
            req_i.b  = $urandom();
            exp_q[i] = model_result(req_i.op, req_i.a, req_i.b);
         end
         else
         begin
            valid_i = 1'b0;
         end
      end
      finish_test("stream");
   endtask

   task automatic test_hold();
      logic [31:0] a;
      logic [31:0] b;
      logic [31:0] expected;
      a = $urandom();
      b = $urandom();
      expected = model_result(OP_MULHU, a, b);
      run_op(OP_MULHU, a, b);
      // the request bus keeps moving while valid_i is low
      repeat (10)
      begin
         @(negedge clk);
         check_value(expected, "hold");
         req_i.op = mul_op_e'($urandom_range(8, 0));
         req_i.a  = $urandom();
         req_i.b  = $urandom();
      end
      finish_test("hold");
   endtask

   initial
   begin
      seed_val    = $urandom(SEED);
      reset_i     = 1'b1;
      valid_i     = 1'b0;
      req_i       = '0;
      check_count = 0;
      error_count = 0;
      test_errors = 0;
      corners     = '{32'h0, 32'h1, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset_i = 1'b0;
      test_reset();
      test_int_mul();
      test_clmul();
      test_grev_gorc();
      test_stream();
      test_hold();
      $display("checks: %0d, errors: %0d", check_count, error_count);
      if (error_count == 0)
      begin
         $display("*** TEST PASSED ***");
      end
      else
      begin
         $display("*** TEST FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* flist.f */
+incdir+include
verilog/mul_pkg.sv
verilog/mul_issue_stage.sv
verilog/mul_operand_stage.sv
verilog/bitmanip_unit.sv
verilog/mul_execute_stage.sv
verilog/mul_top.sv
verif/mul_tb.sv
